// File: exec_unit.sv
`include "rv_core_settings.svh"

module exec_unit (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 head_valid_i,
    input  logic [`XLEN-1:0]     pc_i,
    input  rv_core_pkg::alu_op_e alu_op_i,
    input  logic [`XLEN-1:0]     operand1_i,
    input  logic [`XLEN-1:0]     operand2_i,
    input  logic                 wena_i,
    input  logic [4:0]           waddr_i,
    input  logic [`XLEN-1:0]     jump_target_i,
    input  logic                 ebreak_i,
    output logic                 pop_o,
    output logic                 rf_wen_o,
    output logic [`XLEN-1:0]     rf_wdata_o,
    output logic                 redirect_o,
    output logic [`XLEN-1:0]     redirect_pc_o,
    output logic                 halted_o,

    // Retire trace
    output logic                 retire_valid_o,
    output logic [`XLEN-1:0]     retire_pc_o,
    output logic                 retire_wen_o,
    output logic [4:0]           retire_waddr_o,
    output logic [`XLEN-1:0]     retire_wdata_o
);
    import rv_core_pkg::*;

    logic [`XLEN-1:0] alu_sum;

    // Every supported op reduces to one add
    assign alu_sum = operand1_i + operand2_i;

    assign pop_o         = head_valid_i && !halted_o;
    assign rf_wen_o      = pop_o && wena_i;
    assign rf_wdata_o    = alu_sum;
    assign redirect_o    = pop_o && ((alu_op_i == JAL) || (alu_op_i == JALR));
    assign redirect_pc_o = jump_target_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            halted_o       <= 1'b0;
            retire_valid_o <= 1'b0;
            retire_wen_o   <= 1'b0;
        end else begin
            // Sticky until reset
            if (pop_o && ebreak_i) begin
                halted_o <= 1'b1;
            end
            retire_valid_o <= pop_o;
            retire_wen_o   <= rf_wen_o;
        end
    end

    always_ff @(posedge clk) begin
        retire_pc_o    <= pc_i;
        retire_waddr_o <= rf_wen_o ? waddr_i : 5'd0;
        retire_wdata_o <= rf_wen_o ? alu_sum : '0;
    end

    // Jump retires with a pop, then the flushed queue leaves no head
    a_redirect_pop: assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_o |-> pop_o ##1 !pop_o);

endmodule

// File: inst_decode.sv
`include "rv_core_settings.svh"

module inst_decode (
    input  logic                  head_valid_i,
    input  logic [`XLEN-1:0]      pc_i,
    input  rv_core_pkg::inst_t    inst_i,

    // Register file
    input  logic [`XLEN-1:0]      data1_i,
    input  logic [`XLEN-1:0]      data2_i,
    output logic [4:0]            raddr1_o,
    output logic [4:0]            raddr2_o,

    // Execute unit
    output rv_core_pkg::alu_op_e  alu_op_o,
    output logic [`XLEN-1:0]      operand1_o,
    output logic [`XLEN-1:0]      operand2_o,
    output logic                  wena_o,
    output logic [4:0]            waddr_o,
    output logic [`XLEN-1:0]      jump_target_o,
    output logic                  ebreak_o
);
    import rv_core_pkg::*;

    logic             is_addi;
    logic             is_add;
    logic             is_lui;
    logic             is_auipc;
    logic             is_jal;
    logic             is_jalr;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] link_pc;

    assign is_addi  = (inst_i.r.opcode == OPCODE_OP_IMM) && (inst_i.r.funct3 == FUNCT3_ADD);
    assign is_add   = (inst_i.r.opcode == OPCODE_OP) && (inst_i.r.funct3 == FUNCT3_ADD)
                      && (inst_i.r.funct7 == FUNCT7_ADD);
    assign is_lui   = (inst_i.r.opcode == OPCODE_LUI);
    assign is_auipc = (inst_i.r.opcode == OPCODE_AUIPC);
    assign is_jal   = (inst_i.r.opcode == OPCODE_JAL);
    assign is_jalr  = (inst_i.r.opcode == OPCODE_JALR) && (inst_i.r.funct3 == 3'b000);

    assign ebreak_o = head_valid_i && (inst_i.r.opcode == OPCODE_SYSTEM)
                      && (inst_i.r.funct3 == 3'b000) && (inst_i.i.imm_11_0 == FUNCT12_EBREAK);

    // Sign extended immediates
    assign imm_i = {{20{inst_i.i.imm_11_0[11]}}, inst_i.i.imm_11_0};
    assign imm_u = {inst_i.u.imm_31_12, 12'b0};
    assign imm_j = {{12{inst_i.j.imm_20}}, inst_i.j.imm_19_12, inst_i.j.imm_11,
                    inst_i.j.imm_10_1, 1'b0};

    assign link_pc = pc_i + `XLEN'd4;

    assign raddr1_o = (is_addi || is_add || is_jalr) ? inst_i.r.rs1 : 5'd0;
    assign raddr2_o = is_add ? inst_i.r.rs2 : 5'd0;

    always_comb begin
        if (!head_valid_i) begin
            alu_op_o = NOP;
        end else if (is_addi || is_add || is_lui || is_auipc) begin
            alu_op_o = ADD;
        end else if (is_jal) begin
            alu_op_o = JAL;
        end else if (is_jalr) begin
            alu_op_o = JALR;
        end else begin
            alu_op_o = NOP;
        end
    end

    always_comb begin
        operand1_o = '0;
        operand2_o = '0;
        if (is_addi) begin
            operand1_o = data1_i;
            operand2_o = imm_i;
        end else if (is_add) begin
            operand1_o = data1_i;
            operand2_o = data2_i;
        end else if (is_lui) begin
            operand2_o = imm_u;
        end else if (is_auipc) begin
            operand1_o = pc_i;
            operand2_o = imm_u;
        end else if (is_jal || is_jalr) begin
            // Link value goes through the adder as zero plus pc+4
            operand2_o = link_pc;
        end
    end

    // No write-back for x0 or an empty head
    assign wena_o  = head_valid_i && (inst_i.r.rd != 5'd0)
                     && (is_addi || is_add || is_lui || is_auipc || is_jal || is_jalr);
    assign waddr_o = inst_i.r.rd;

    assign jump_target_o = is_jal  ? pc_i + imm_j :
                           is_jalr ? ((data1_i + imm_i) & ~`XLEN'd1) : '0;

endmodule

// File: inst_fetch.sv
`include "rv_core_settings.svh"

module inst_fetch (
    input  logic               clk,
    input  logic               rst_n_i,

    // AXI4-Lite read master
    output logic [`XLEN-1:0]   m_araddr_o,
    output logic               m_arvalid_o,
    input  logic               m_arready_i,
    input  logic [`XLEN-1:0]   m_rdata_i,
    input  logic               m_rvalid_i,
    output logic               m_rready_o,

    // Instruction queue
    input  logic               iq_full_i,
    output logic               push_o,
    output logic [`XLEN-1:0]   push_pc_o,
    output rv_core_pkg::inst_t push_inst_o,

    // Back end control
    input  logic               redirect_i,
    input  logic [`XLEN-1:0]   redirect_pc_i,
    input  logic               halted_i
);
    logic [`XLEN-1:0] pc_q;
    logic             r_pending;
    logic             drop_q;
    logic             ar_fire;
    logic             r_fire;
    logic             ar_start;

    assign ar_fire  = m_arvalid_o && m_arready_i;
    assign r_fire   = m_rvalid_i && m_rready_o;
    // Only one request in flight, so wait for both channels to go idle
    assign ar_start = !m_arvalid_o && !r_pending && !iq_full_i && !halted_i && !redirect_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q        <= `RESET_PC;
            m_arvalid_o <= 1'b0;
            r_pending   <= 1'b0;
            drop_q      <= 1'b0;
        end else begin
            if (ar_start) begin
                m_arvalid_o <= 1'b1;
            end else if (ar_fire) begin
                m_arvalid_o <= 1'b0;
            end

            if (ar_fire) begin
                r_pending <= 1'b1;
            end else if (r_fire) begin
                r_pending <= 1'b0;
            end

            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (ar_start) begin
                pc_q <= pc_q + `XLEN'd4;
            end

            // Stale request still out in memory
            if (redirect_i && (m_arvalid_o || (r_pending && !r_fire))) begin
                drop_q <= 1'b1;
            end else if (r_fire) begin
                drop_q <= 1'b0;
            end
        end
    end

    // Address is held until the next request opens
    always_ff @(posedge clk) begin
        if (ar_start) begin
            m_araddr_o <= pc_q;
        end
    end

    assign m_rready_o  = r_pending;
    assign push_o      = r_fire && !drop_q;
    assign push_pc_o   = m_araddr_o;
    assign push_inst_o = m_rdata_i;

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o));

endmodule

// File: inst_queue.sv
`include "rv_core_settings.svh"

module inst_queue (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               flush_i,
    input  logic               push_i,
    input  logic [`XLEN-1:0]   push_pc_i,
    input  rv_core_pkg::inst_t push_inst_i,
    output logic               full_o,
    output logic               head_valid_o,
    output logic [`XLEN-1:0]   head_pc_o,
    output rv_core_pkg::inst_t head_inst_o,
    input  logic               pop_i
);
    import rv_core_pkg::*;

    localparam int AW = $clog2(`IQ_DEPTH);

    logic [`XLEN-1:0] pc_mem [`IQ_DEPTH];
    inst_t            inst_mem [`IQ_DEPTH];
    // Extra top bit tells full from empty
    logic [AW:0]      wr_ptr;
    logic [AW:0]      rd_ptr;

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            pc_mem[wr_ptr[AW-1:0]]   <= push_pc_i;
            inst_mem[wr_ptr[AW-1:0]] <= push_inst_i;
        end
    end

    assign full_o       = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign head_valid_o = (wr_ptr != rd_ptr);
    assign head_pc_o    = pc_mem[rd_ptr[AW-1:0]];
    assign head_inst_o  = inst_mem[rd_ptr[AW-1:0]];

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
        push_i |-> !full_o);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n_i)
        pop_i |-> head_valid_o);

endmodule

// File: regfile.sv
`include "rv_core_settings.svh"

module regfile (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic [4:0]       raddr1_i,
    input  logic [4:0]       raddr2_i,
    output logic [`XLEN-1:0] rdata1_o,
    output logic [`XLEN-1:0] rdata2_o,
    input  logic             wen_i,
    input  logic [4:0]       waddr_i,
    input  logic [`XLEN-1:0] wdata_i
);
    logic [`XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wen_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 always reads zero
    assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs[raddr2_i];

endmodule

// File: run.sh
#!/bin/sh
# Build the core and its testbench with Verilator, then run the simulation
verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core -f vlog.f \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_rv_core > sim.log 2>&1
cat sim.log

# A reported failure or a run that never completed both count as failing
grep -q "TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "Simulation did not complete"; exit 1; }
exit 0

// File: rv_core_pkg.sv
package rv_core_pkg;

    // Base opcodes
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

    localparam logic [2:0]  FUNCT3_ADD     = 3'b000;
    localparam logic [6:0]  FUNCT7_ADD     = 7'b0000000;
    localparam logic [11:0] FUNCT12_EBREAK = 12'h001;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // One instruction word, six encodings
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } inst_t;

    typedef enum logic [2:0] {
        NOP,
        ADD,
        JAL,
        JALR
    } alu_op_e;

endpackage

// File: rv_core_settings.svh
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// Data and address width of the core
`define XLEN 32

// Instruction queue entries, power of two only
`define IQ_DEPTH 4

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// File: rv_core_top.sv
`include "rv_core_settings.svh"

module rv_core_top (
    input  logic             clk,
    input  logic             rst_n_i,

    // Instruction memory, AXI4-Lite read channels
    output logic [`XLEN-1:0] m_araddr_o,
    output logic             m_arvalid_o,
    input  logic             m_arready_i,
    input  logic [`XLEN-1:0] m_rdata_i,
    input  logic             m_rvalid_i,
    output logic             m_rready_o,

    output logic             halted_o,

    // Retire trace
    output logic             retire_valid_o,
    output logic [`XLEN-1:0] retire_pc_o,
    output logic             retire_wen_o,
    output logic [4:0]       retire_waddr_o,
    output logic [`XLEN-1:0] retire_wdata_o
);
    import rv_core_pkg::*;

    logic             iq_full;
    logic             push;
    logic [`XLEN-1:0] push_pc;
    inst_t            push_inst;
    logic             head_valid;
    logic [`XLEN-1:0] head_pc;
    inst_t            head_inst;
    logic             pop;
    logic             redirect;
    logic [`XLEN-1:0] redirect_pc;
    logic [4:0]       raddr1;
    logic [4:0]       raddr2;
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
    alu_op_e          alu_op;
    logic [`XLEN-1:0] operand1;
    logic [`XLEN-1:0] operand2;
    logic             wena;
    logic [4:0]       waddr;
    logic [`XLEN-1:0] jump_target;
    logic             ebreak;
    logic             rf_wen;
    logic [`XLEN-1:0] rf_wdata;

    inst_fetch i_inst_fetch (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .m_araddr_o    (m_araddr_o),
        .m_arvalid_o   (m_arvalid_o),
        .m_arready_i   (m_arready_i),
        .m_rdata_i     (m_rdata_i),
        .m_rvalid_i    (m_rvalid_i),
        .m_rready_o    (m_rready_o),
        .iq_full_i     (iq_full),
        .push_o        (push),
        .push_pc_o     (push_pc),
        .push_inst_o   (push_inst),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .halted_i      (halted_o)
    );

    // Redirect flushes everything fetched down the old path
    inst_queue i_inst_queue (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (redirect),
        .push_i       (push),
        .push_pc_i    (push_pc),
        .push_inst_i  (push_inst),
        .full_o       (iq_full),
        .head_valid_o (head_valid),
        .head_pc_o    (head_pc),
        .head_inst_o  (head_inst),
        .pop_i        (pop)
    );

    inst_decode i_inst_decode (
        .head_valid_i  (head_valid),
        .pc_i          (head_pc),
        .inst_i        (head_inst),
        .data1_i       (rdata1),
        .data2_i       (rdata2),
        .raddr1_o      (raddr1),
        .raddr2_o      (raddr2),
        .alu_op_o      (alu_op),
        .operand1_o    (operand1),
        .operand2_o    (operand2),
        .wena_o        (wena),
        .waddr_o       (waddr),
        .jump_target_o (jump_target),
        .ebreak_o      (ebreak)
    );

    regfile i_regfile (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .wen_i    (rf_wen),
        .waddr_i  (waddr),
        .wdata_i  (rf_wdata)
    );

    exec_unit i_exec_unit (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .head_valid_i   (head_valid),
        .pc_i           (head_pc),
        .alu_op_i       (alu_op),
        .operand1_i     (operand1),
        .operand2_i     (operand2),
        .wena_i         (wena),
        .waddr_i        (waddr),
        .jump_target_i  (jump_target),
        .ebreak_i       (ebreak),
        .pop_o          (pop),
        .rf_wen_o       (rf_wen),
        .rf_wdata_o     (rf_wdata),
        .redirect_o     (redirect),
        .redirect_pc_o  (redirect_pc),
        .halted_o       (halted_o),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_wen_o   (retire_wen_o),
        .retire_waddr_o (retire_waddr_o),
        .retire_wdata_o (retire_wdata_o)
    );

endmodule

// File: tb_rv_core.sv
`include "rv_core_settings.svh"

module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_core_pkg::*;

    localparam int MEM_WORDS      = 32;
    localparam int NUM_ROWS       = 12;
    localparam int RETIRE_TIMEOUT = 200;
    localparam int HALT_TIMEOUT   = 50;
    localparam int QUIET_CYCLES   = 50;

    // One expected retirement per row in program order
    localparam logic [31:0] EXP_PC [NUM_ROWS] = '{
        32'h00, 32'h04, 32'h08, 32'h0C, 32'h10, 32'h14,
        32'h18, 32'h1C, 32'h28, 32'h2C, 32'h44, 32'h48
    };
    localparam logic EXP_WEN [NUM_ROWS] = '{
        1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1,
        1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0
    };
    localparam logic [4:0] EXP_WADDR [NUM_ROWS] = '{
        5'd1, 5'd2, 5'd3, 5'd0, 5'd4, 5'd5,
        5'd6, 5'd7, 5'd9, 5'd10, 5'd12, 5'd0
    };
    localparam logic [31:0] EXP_WDATA [NUM_ROWS] = '{
        32'h0000_0005, 32'h0000_0002, 32'h0000_0007, 32'h0000_0000,
        32'h0000_0007, 32'h1234_5000, 32'h0000_1018, 32'h0000_0020,
        32'h0000_0040, 32'h0000_0030, 32'hFFFF_FFFF, 32'h0000_0000
    };

    logic              clk            = 1'b0;
    logic              rst_n_i        = 1'b0;
    logic              m_arready_i    = 1'b0;
    logic [`XLEN-1:0]  m_rdata_i      = '0;
    logic              m_rvalid_i     = 1'b0;
    logic [`XLEN-1:0]  m_araddr_o;
    logic              m_arvalid_o;
    logic              m_rready_o;
    logic              halted_o;
    logic              retire_valid_o;
    logic [`XLEN-1:0]  retire_pc_o;
    logic              retire_wen_o;
    logic [4:0]        retire_waddr_o;
    logic [`XLEN-1:0]  retire_wdata_o;

    integer            seed = 32'heca6;
    logic [31:0]       prog [MEM_WORDS];

    // Memory model state
    logic              ar_armed = 1'b0;
    logic [1:0]        ar_cnt   = '0;
    logic [1:0]        ar_draw;
    logic              r_busy   = 1'b0;
    logic [1:0]        r_cnt    = '0;
    logic [`XLEN-1:0]  r_addr   = '0;

    rv_core_top i_rv_core_top (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .m_araddr_o     (m_araddr_o),
        .m_arvalid_o    (m_arvalid_o),
        .m_arready_i    (m_arready_i),
        .m_rdata_i      (m_rdata_i),
        .m_rvalid_i     (m_rvalid_i),
        .m_rready_o     (m_rready_o),
        .halted_o       (halted_o),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_wen_o   (retire_wen_o),
        .retire_waddr_o (retire_waddr_o),
        .retire_wdata_o (retire_wdata_o)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    // Encoders for the I, R, U and J formats with funct3 zero
    function automatic logic [31:0] enc_i(logic [6:0] op, logic [4:0] rd, logic [4:0] rs1,
                                          logic [11:0] imm);
        return {imm, rs1, FUNCT3_ADD, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        return {FUNCT7_ADD, rs2, rs1, FUNCT3_ADD, rd, OPCODE_OP};
    endfunction

    function automatic logic [31:0] enc_u(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPCODE_JAL};
    endfunction

    function automatic void load_program();
        // Filler adds its own byte address to x13
        for (int idx = 0; idx < MEM_WORDS; idx++) begin
            prog[idx] = enc_i(OPCODE_OP_IMM, 5'd13, 5'd13, 12'(idx * 4));
        end
        prog[0]  = enc_i(OPCODE_OP_IMM, 5'd1, 5'd0, 12'd5);
        prog[1]  = enc_i(OPCODE_OP_IMM, 5'd2, 5'd1, 12'hFFD);
        prog[2]  = enc_r(5'd3, 5'd1, 5'd2);
        prog[3]  = enc_i(OPCODE_OP_IMM, 5'd0, 5'd3, 12'd9);
        prog[4]  = enc_r(5'd4, 5'd0, 5'd3);
        prog[5]  = enc_u(OPCODE_LUI, 5'd5, 20'h12345);
        prog[6]  = enc_u(OPCODE_AUIPC, 5'd6, 20'h00001);
        prog[7]  = enc_j(5'd7, 21'd12);
        // Fetched behind the jal and never retired
        prog[8]  = enc_i(OPCODE_OP_IMM, 5'd8, 5'd0, 12'd99);
        prog[9]  = enc_i(OPCODE_OP_IMM, 5'd8, 5'd0, 12'd98);
        prog[10] = enc_i(OPCODE_OP_IMM, 5'd9, 5'd0, 12'h040);
        prog[11] = enc_i(OPCODE_JALR, 5'd10, 5'd9, 12'd5);
        prog[12] = enc_i(OPCODE_OP_IMM, 5'd11, 5'd0, 12'd1);
        // Decoy just below the jalr target
        prog[16] = enc_i(OPCODE_OP_IMM, 5'd12, 5'd0, 12'd77);
        prog[17] = enc_i(OPCODE_OP_IMM, 5'd12, 5'd12, 12'hFFF);
        prog[18] = {FUNCT12_EBREAK, 5'd0, 3'b000, 5'd0, OPCODE_SYSTEM};
    endfunction

    function automatic logic [1:0] rand_delay();
        int r;
        r = $random(seed);
        return r[1:0];
    endfunction

    task automatic stop_on_failure();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic report_problem(input string what);
        $display("Failure at %0d ns: %s", $time, what);
        stop_on_failure();
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0d ns: %s is 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            stop_on_failure();
        end
    endtask

    task automatic wait_retire(input int row);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!retire_valid_o) begin
            if (cycles >= RETIRE_TIMEOUT) begin
                report_problem($sformatf("no retirement for row %0d within %0d cycles",
                                         row, RETIRE_TIMEOUT));
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic wait_halt();
        int cycles;
        cycles = 0;
        while (!halted_o) begin
            if (cycles >= HALT_TIMEOUT) begin
                report_problem("the core did not halt after ebreak retired");
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic check_quiet();
        for (int cyc = 0; cyc < QUIET_CYCLES; cyc++) begin
            @(negedge clk);
            if (retire_valid_o) begin
                report_problem($sformatf("instruction at pc 0x%08h retired after halt",
                                         retire_pc_o));
            end
        end
    endtask

    // AXI4-Lite read slave with random AR and R delays
    always @(posedge clk) begin
        if (!rst_n_i) begin
            m_arready_i <= 1'b0;
            m_rvalid_i  <= 1'b0;
            ar_armed    <= 1'b0;
            r_busy      <= 1'b0;
        end else begin
            if (m_arvalid_o && m_arready_i) begin
                if (m_araddr_o >= 32'(MEM_WORDS * 4)) begin
                    report_problem("fetch address lies outside the program memory");
                end
                m_arready_i <= 1'b0;
                ar_armed    <= 1'b0;
                r_busy      <= 1'b1;
                r_addr      <= m_araddr_o;
                r_cnt       <= rand_delay();
            end else if (m_arvalid_o && !ar_armed) begin
                ar_armed <= 1'b1;
                ar_draw = rand_delay();
                if (ar_draw == 2'd0) begin
                    m_arready_i <= 1'b1;
                end else begin
                    ar_cnt <= ar_draw - 2'd1;
                end
            end else if (ar_armed && !m_arready_i) begin
                if (ar_cnt == 2'd0) begin
                    m_arready_i <= 1'b1;
                end else begin
                    ar_cnt <= ar_cnt - 2'd1;
                end
            end

            if (m_rvalid_i && m_rready_o) begin
                m_rvalid_i <= 1'b0;
                r_busy     <= 1'b0;
            end else if (r_busy && !m_rvalid_i) begin
                if (r_cnt == 2'd0) begin
                    m_rvalid_i <= 1'b1;
                    m_rdata_i  <= prog[r_addr[6:2]];
                end else begin
                    r_cnt <= r_cnt - 2'd1;
                end
            end
        end
    end

    initial begin
        load_program();
        repeat (10) @(posedge clk);
        rst_n_i <= 1'b1;

        for (int row = 0; row < NUM_ROWS; row++) begin
            wait_retire(row);
            check_value("retire_pc_o", retire_pc_o, EXP_PC[row]);
            check_value("retire_wen_o", {31'b0, retire_wen_o}, {31'b0, EXP_WEN[row]});
            check_value("retire_waddr_o", {27'b0, retire_waddr_o}, {27'b0, EXP_WADDR[row]});
            check_value("retire_wdata_o", retire_wdata_o, EXP_WDATA[row]);
        end

        wait_halt();
        check_quiet();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+.
rv_core_pkg.sv
inst_fetch.sv
inst_queue.sv
inst_decode.sv
regfile.sv
exec_unit.sv
rv_core_top.sv
tb_rv_core.sv
